// ==== aes_defines.svh ====
`ifndef AES_DEFINES_SVH
`define AES_DEFINES_SVH

// Bus widths
`define AES_ADDR_WIDTH 12
`define AES_DATA_WIDTH 32

// AES-128 round count
`define AES_ROUNDS 10

// Register map, each group holds four words with word 0 as bits 127:96
`define AES_CTRL   12'h000
`define AES_STATUS 12'h004
`define AES_KEY0   12'h010
`define AES_DIN0   12'h020
`define AES_DOUT0  12'h030

`endif

// ==== aes_types_pkg.sv ====
package aes_types_pkg;

  // Full state or cipher key, FIPS byte 0 in bits 127:120
  typedef logic [127:0] aes_block_t;

  // One state column or key schedule word
  typedef logic [31:0] aes_word_t;

  typedef logic [7:0] aes_byte_t;

  // Round counter, runs 1 to 10
  typedef logic [3:0] aes_round_t;

  typedef enum logic [1:0] {
    IDLE,
    ROUND,
    DONE
  } aes_core_state_e;

endpackage

// ==== axi_regs_pkg.sv ====
`include "aes_defines.svh"

package axi_regs_pkg;

  typedef logic [`AES_ADDR_WIDTH-1:0] bus_addr_t;
  typedef logic [`AES_DATA_WIDTH-1:0] bus_data_t;
  typedef logic [`AES_DATA_WIDTH/8-1:0] bus_strb_t;
  typedef logic [1:0] bus_resp_t;

  localparam bus_resp_t RESP_OKAY   = 2'b00;
  localparam bus_resp_t RESP_SLVERR = 2'b10;

endpackage

// ==== aes_ifs.sv ====
`timescale 1ns/1ps

// Register access port between the AXI slave and the register file
interface reg_bus_if;
  import axi_regs_pkg::*;

  logic      we;
  logic      re;
  bus_addr_t addr;
  bus_data_t wdata;
  bus_strb_t strb;
  bus_data_t rdata;
  logic      err;

  modport master (output we, re, addr, wdata, strb, input rdata, err);
  modport slave (input we, re, addr, wdata, strb, output rdata, err);
endinterface

// Run control between the register file and the round core
interface aes_ctrl_if;
  import aes_types_pkg::*;

  logic       start;
  aes_block_t key;
  aes_block_t block;
  logic       busy;
  logic       done;
  aes_block_t result;

  modport host (output start, key, block, input busy, done, result);
  modport engine (input start, key, block, output busy, done, result);
endinterface

// ==== aes_sbox.sv ====
`timescale 1ns/1ps

module aes_sbox (
  input  aes_types_pkg::aes_byte_t byte_i,
  output aes_types_pkg::aes_byte_t byte_o
);
  import aes_types_pkg::*;

  aes_byte_t x2;
  aes_byte_t x3;
  aes_byte_t x12;
  aes_byte_t x15;
  aes_byte_t x60;
  aes_byte_t x240;
  aes_byte_t inv;

  // Multiply modulo x^8 + x^4 + x^3 + x + 1
  function automatic aes_byte_t gf_mul(input aes_byte_t a, input aes_byte_t b);
    aes_byte_t prod;
    aes_byte_t acc;
    prod = '0;
    acc  = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        prod = prod ^ acc;
      end
      acc = {acc[6:0], 1'b0} ^ (acc[7] ? 8'h1b : 8'h00);
    end
    return prod;
  endfunction

  // Inverse as x^254 so that zero maps to zero
  assign x2   = gf_mul(byte_i, byte_i);
  assign x3   = gf_mul(x2, byte_i);
  assign x12  = gf_mul(gf_mul(x3, x3), gf_mul(x3, x3));
  assign x15  = gf_mul(x12, x3);
  assign x60  = gf_mul(gf_mul(x15, x15), gf_mul(x15, x15));
  assign x240 = gf_mul(gf_mul(x60, x60), gf_mul(x60, x60));
  assign inv  = gf_mul(gf_mul(x240, x12), x2);

  // Affine transform
  assign byte_o = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^
                  {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;

endmodule

// ==== aes_round_core.sv ====
`timescale 1ns/1ps
`include "aes_defines.svh"

module aes_round_core (
  input logic         clk_i,
  input logic         rst_ni,
  aes_ctrl_if.engine  ctrl
);
  import aes_types_pkg::*;

  aes_core_state_e state_q;
  aes_round_t      round_q;
  aes_block_t      data_q;
  aes_block_t      rkey_q;
  aes_block_t      result_q;

  aes_block_t sub_bytes;
  aes_block_t shifted;
  aes_block_t mixed;
  aes_block_t next_key;
  aes_block_t round_out;
  aes_word_t  rot_word;
  aes_word_t  sub_word;
  aes_word_t  key_temp;
  logic       last_round;

  function automatic aes_byte_t xtime(input aes_byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  function automatic aes_word_t mix_column(input aes_word_t col);
    aes_byte_t a0, a1, a2, a3;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
            xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
  endfunction

  function automatic aes_byte_t rcon(input aes_round_t r);
    case (r)
      4'd1:    rcon = 8'h01;
      4'd2:    rcon = 8'h02;
      4'd3:    rcon = 8'h04;
      4'd4:    rcon = 8'h08;
      4'd5:    rcon = 8'h10;
      4'd6:    rcon = 8'h20;
      4'd7:    rcon = 8'h40;
      4'd8:    rcon = 8'h80;
      4'd9:    rcon = 8'h1b;
      4'd10:   rcon = 8'h36;
      default: rcon = 8'h00;
    endcase
  endfunction

  // ----------------------------------------------------------
  // Round datapath
  // ----------------------------------------------------------
  for (genvar i = 0; i < 16; i++) begin : g_sub_bytes
    aes_sbox u_sbox (
      .byte_i (data_q[127-8*i -: 8]),
      .byte_o (sub_bytes[127-8*i -: 8])
    );
  end

  // Row r rotates left by r columns
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shifted[127-8*(4*c+r) -: 8] = sub_bytes[127-8*(4*((c+r)%4)+r) -: 8];
      end
    end
  end

  always_comb begin
    for (int c = 0; c < 4; c++) begin
      mixed[127-32*c -: 32] = mix_column(shifted[127-32*c -: 32]);
    end
  end

  assign last_round = (round_q == `AES_ROUNDS);
  assign round_out  = (last_round ? shifted : mixed) ^ next_key;

  // ----------------------------------------------------------
  // Key schedule computed on the fly
  // ----------------------------------------------------------
  assign rot_word = {rkey_q[23:0], rkey_q[31:24]};

  for (genvar i = 0; i < 4; i++) begin : g_sub_word
    aes_sbox u_sbox (
      .byte_i (rot_word[31-8*i -: 8]),
      .byte_o (sub_word[31-8*i -: 8])
    );
  end

  assign key_temp         = sub_word ^ {rcon(round_q), 24'h000000};
  assign next_key[127:96] = rkey_q[127:96] ^ key_temp;
  assign next_key[95:64]  = rkey_q[95:64] ^ rkey_q[127:96] ^ key_temp;
  assign next_key[63:32]  = rkey_q[63:32] ^ rkey_q[95:64] ^ rkey_q[127:96] ^ key_temp;
  assign next_key[31:0]   = rkey_q[31:0] ^ rkey_q[63:32] ^ rkey_q[95:64] ^
                            rkey_q[127:96] ^ key_temp;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      round_q  <= '0;
      result_q <= '0;
    end else begin
      case (state_q)
        ROUND: begin
          round_q <= round_q + 4'd1;
          if (last_round) begin
            state_q  <= DONE;
            result_q <= round_out;
          end
        end
        default: begin
          if (ctrl.start) begin
            state_q <= ROUND;
            round_q <= 4'd1;
          end else begin
            state_q <= IDLE;
          end
        end
      endcase
    end
  end

  // Initial AddRoundKey happens as the block is loaded
  always_ff @(posedge clk_i) begin
    if (state_q == ROUND) begin
      data_q <= round_out;
      rkey_q <= next_key;
    end else if (ctrl.start) begin
      data_q <= ctrl.block ^ ctrl.key;
      rkey_q <= ctrl.key;
    end
  end

  assign ctrl.busy   = (state_q == ROUND);
  assign ctrl.done   = (state_q == DONE);
  assign ctrl.result = result_q;

endmodule

// ==== aes_reg_file.sv ====
`timescale 1ns/1ps
`include "aes_defines.svh"

module aes_reg_file (
  input  logic        clk_i,
  input  logic        rst_ni,
  reg_bus_if.slave    bus,
  aes_ctrl_if.host    ctrl,
  input  logic        irq_clear_i,
  output logic        irq_o
);
  import axi_regs_pkg::*;

  bus_data_t key_q [4];
  bus_data_t din_q [4];
  logic      start_q;
  logic      irq_q;

  bus_addr_t word_addr;
  bus_addr_t group_addr;
  logic [1:0] word_idx;
  logic      is_ctrl;
  logic      is_status;
  logic      is_key;
  logic      is_din;
  logic      is_dout;
  logic      status_clr;
  logic      wr_err;
  logic      rd_err;
  bus_data_t rd_data;

  function automatic bus_data_t merge_bytes(input bus_data_t old_word,
                                            input bus_data_t new_word,
                                            input bus_strb_t strb);
    bus_data_t res;
    res = old_word;
    for (int b = 0; b < `AES_DATA_WIDTH/8; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  // ----------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------
  assign word_addr  = {bus.addr[`AES_ADDR_WIDTH-1:2], 2'b00};
  assign group_addr = {bus.addr[`AES_ADDR_WIDTH-1:4], 4'h0};
  assign word_idx   = bus.addr[3:2];

  assign is_ctrl   = (word_addr == `AES_CTRL);
  assign is_status = (word_addr == `AES_STATUS);
  assign is_key    = (group_addr == `AES_KEY0);
  assign is_din    = (group_addr == `AES_DIN0);
  assign is_dout   = (group_addr == `AES_DOUT0);

  // DOUT is read-only, so it counts as a bad write target
  assign wr_err = !(is_ctrl || is_status || is_key || is_din);
  assign rd_err = !(is_ctrl || is_status || is_key || is_din || is_dout);

  assign status_clr = bus.we && is_status && bus.strb[0] && bus.wdata[1];

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < 4; i++) begin
        key_q[i] <= '0;
        din_q[i] <= '0;
      end
      start_q <= 1'b0;
      irq_q   <= 1'b0;
    end else begin
      start_q <= bus.we && is_ctrl && bus.strb[0] && bus.wdata[0];
      if (bus.we && is_key) begin
        key_q[word_idx] <= merge_bytes(key_q[word_idx], bus.wdata, bus.strb);
      end
      if (bus.we && is_din) begin
        din_q[word_idx] <= merge_bytes(din_q[word_idx], bus.wdata, bus.strb);
      end
      // A finishing block wins over a clear in the same cycle
      if (ctrl.done) begin
        irq_q <= 1'b1;
      end else if (irq_clear_i || status_clr) begin
        irq_q <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------
  // Read data
  // ----------------------------------------------------------
  always_comb begin
    rd_data = '0;
    if (is_status) begin
      // Busy also covers the cycle the start pulse is in flight
      rd_data = {{(`AES_DATA_WIDTH-2){1'b0}}, irq_q, ctrl.busy || start_q};
    end else if (is_key) begin
      rd_data = key_q[word_idx];
    end else if (is_din) begin
      rd_data = din_q[word_idx];
    end else if (is_dout) begin
      rd_data = ctrl.result[127-32*word_idx -: 32];
    end
  end

  assign bus.rdata = bus.re ? rd_data : '0;
  assign bus.err   = (bus.we && wr_err) || (bus.re && rd_err);

  assign ctrl.start = start_q;
  assign ctrl.key   = {key_q[0], key_q[1], key_q[2], key_q[3]};
  assign ctrl.block = {din_q[0], din_q[1], din_q[2], din_q[3]};
  assign irq_o      = irq_q;

endmodule

// ==== axi_lite_slave.sv ====
`timescale 1ns/1ps

module axi_lite_slave (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Write address and data
  input  axi_regs_pkg::bus_addr_t awaddr_i,
  input  logic                    awvalid_i,
  output logic                    awready_o,
  input  axi_regs_pkg::bus_data_t wdata_i,
  input  axi_regs_pkg::bus_strb_t wstrb_i,
  input  logic                    wvalid_i,
  output logic                    wready_o,
  // Write response
  output axi_regs_pkg::bus_resp_t bresp_o,
  output logic                    bvalid_o,
  input  logic                    bready_i,
  // Read address and data
  input  axi_regs_pkg::bus_addr_t araddr_i,
  input  logic                    arvalid_i,
  output logic                    arready_o,
  output axi_regs_pkg::bus_data_t rdata_o,
  output axi_regs_pkg::bus_resp_t rresp_o,
  output logic                    rvalid_o,
  input  logic                    rready_i,
  reg_bus_if.master               bus
);
  import axi_regs_pkg::*;

  logic      wr_accept;
  logic      rd_accept;
  logic      bvalid_q;
  bus_resp_t bresp_q;
  logic      rvalid_q;
  bus_resp_t rresp_q;
  bus_data_t rdata_q;

  // Only one register access per cycle, so a colliding read waits a cycle
  assign wr_accept = awvalid_i && wvalid_i && !bvalid_q;
  assign rd_accept = arvalid_i && !rvalid_q && !wr_accept;

  assign awready_o = wr_accept;
  assign wready_o  = wr_accept;
  assign arready_o = rd_accept;

  assign bus.we    = wr_accept;
  assign bus.re    = rd_accept;
  assign bus.addr  = wr_accept ? awaddr_i : araddr_i;
  assign bus.wdata = wdata_i;
  assign bus.strb  = wstrb_i;

  // ----------------------------------------------------------
  // Response channels, held until the master takes them
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      bvalid_q <= 1'b0;
      bresp_q  <= RESP_OKAY;
      rvalid_q <= 1'b0;
      rresp_q  <= RESP_OKAY;
      rdata_q  <= '0;
    end else begin
      if (wr_accept) begin
        bvalid_q <= 1'b1;
        bresp_q  <= bus.err ? RESP_SLVERR : RESP_OKAY;
      end else if (bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (rd_accept) begin
        rvalid_q <= 1'b1;
        rresp_q  <= bus.err ? RESP_SLVERR : RESP_OKAY;
        rdata_q  <= bus.rdata;
      end else if (rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  assign bvalid_o = bvalid_q;
  assign bresp_o  = bresp_q;
  assign rvalid_o = rvalid_q;
  assign rresp_o  = rresp_q;
  assign rdata_o  = rdata_q;

endmodule

// ==== aes_axi_top.sv ====
`timescale 1ns/1ps

module aes_axi_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  axi_regs_pkg::bus_addr_t awaddr_i,
  input  logic                    awvalid_i,
  output logic                    awready_o,
  input  axi_regs_pkg::bus_data_t wdata_i,
  input  axi_regs_pkg::bus_strb_t wstrb_i,
  input  logic                    wvalid_i,
  output logic                    wready_o,
  output axi_regs_pkg::bus_resp_t bresp_o,
  output logic                    bvalid_o,
  input  logic                    bready_i,
  input  axi_regs_pkg::bus_addr_t araddr_i,
  input  logic                    arvalid_i,
  output logic                    arready_o,
  output axi_regs_pkg::bus_data_t rdata_o,
  output axi_regs_pkg::bus_resp_t rresp_o,
  output logic                    rvalid_o,
  input  logic                    rready_i,
  output logic                    irq_o,
  input  logic                    irq_clear_i
);

  reg_bus_if  reg_bus ();
  aes_ctrl_if aes_ctrl ();

  axi_lite_slave u_axi_slave (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .awaddr_i  (awaddr_i),
    .awvalid_i (awvalid_i),
    .awready_o (awready_o),
    .wdata_i   (wdata_i),
    .wstrb_i   (wstrb_i),
    .wvalid_i  (wvalid_i),
    .wready_o  (wready_o),
    .bresp_o   (bresp_o),
    .bvalid_o  (bvalid_o),
    .bready_i  (bready_i),
    .araddr_i  (araddr_i),
    .arvalid_i (arvalid_i),
    .arready_o (arready_o),
    .rdata_o   (rdata_o),
    .rresp_o   (rresp_o),
    .rvalid_o  (rvalid_o),
    .rready_i  (rready_i),
    .bus       (reg_bus.master)
  );

  aes_reg_file u_reg_file (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .bus         (reg_bus.slave),
    .ctrl        (aes_ctrl.host),
    .irq_clear_i (irq_clear_i),
    .irq_o       (irq_o)
  );

  aes_round_core u_core (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .ctrl   (aes_ctrl.engine)
  );

endmodule

// ==== tb_aes_model.svh ====
`ifndef TB_AES_MODEL_SVH
`define TB_AES_MODEL_SVH

// Carry-less product reduced by the AES polynomial 0x11b
function automatic logic [7:0] ref_gf_mul(input logic [7:0] a, input logic [7:0] b);
  logic [15:0] p;
  p = '0;
  for (int i = 0; i < 8; i++) begin
    if (b[i]) begin
      p = p ^ (16'(a) << i);
    end
  end
  for (int i = 15; i >= 8; i--) begin
    if (p[i]) begin
      p = p ^ (16'h011b << (i - 8));
    end
  end
  return p[7:0];
endfunction

// Inverse found by search, zero maps to zero
function automatic logic [7:0] ref_sbox(input logic [7:0] x);
  logic [7:0] inv;
  logic [7:0] s;
  inv = 8'h00;
  for (int y = 1; y < 256; y++) begin
    if (ref_gf_mul(x, 8'(y)) == 8'h01) begin
      inv = 8'(y);
    end
  end
  s = 8'h63;
  for (int i = 0; i < 8; i++) begin
    s[i] = s[i] ^ inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8] ^
           inv[(i + 6) % 8] ^ inv[(i + 7) % 8];
  end
  return s;
endfunction

function automatic logic [127:0] ref_encrypt(input logic [127:0] key,
                                             input logic [127:0] pt);
  logic [31:0]  w [44];
  logic [31:0]  temp;
  logic [7:0]   rc;
  logic [7:0]   st [16];
  logic [7:0]   tmp [16];
  logic [7:0]   a0, a1, a2, a3;
  logic [127:0] ct;
  rc = 8'h01;
  for (int i = 0; i < 44; i++) begin
    if (i < 4) begin
      w[i] = key[127-32*i -: 32];
    end else begin
      temp = w[i-1];
      if (i % 4 == 0) begin
        temp = {temp[23:0], temp[31:24]};
        temp = {ref_sbox(temp[31:24]), ref_sbox(temp[23:16]),
                ref_sbox(temp[15:8]), ref_sbox(temp[7:0])};
        temp[31:24] = temp[31:24] ^ rc;
        rc = ref_gf_mul(rc, 8'h02);
      end
      w[i] = w[i-4] ^ temp;
    end
  end
  // Byte j of the state sits at row j%4 and column j/4
  for (int j = 0; j < 16; j++) begin
    st[j] = pt[127-8*j -: 8] ^ w[j/4][31-8*(j%4) -: 8];
  end
  for (int r = 1; r <= 10; r++) begin
    for (int j = 0; j < 16; j++) begin
      tmp[j] = ref_sbox(st[4*(((j / 4) + (j % 4)) % 4) + (j % 4)]);
    end
    for (int c = 0; c < 4; c++) begin
      a0 = tmp[4*c];
      a1 = tmp[4*c+1];
      a2 = tmp[4*c+2];
      a3 = tmp[4*c+3];
      if (r < 10) begin
        st[4*c]   = ref_gf_mul(a0, 8'h02) ^ ref_gf_mul(a1, 8'h03) ^ a2 ^ a3;
        st[4*c+1] = a0 ^ ref_gf_mul(a1, 8'h02) ^ ref_gf_mul(a2, 8'h03) ^ a3;
        st[4*c+2] = a0 ^ a1 ^ ref_gf_mul(a2, 8'h02) ^ ref_gf_mul(a3, 8'h03);
        st[4*c+3] = ref_gf_mul(a0, 8'h03) ^ a1 ^ a2 ^ ref_gf_mul(a3, 8'h02);
      end else begin
        st[4*c]   = a0;
        st[4*c+1] = a1;
        st[4*c+2] = a2;
        st[4*c+3] = a3;
      end
    end
    for (int j = 0; j < 16; j++) begin
      st[j] = st[j] ^ w[4*r + j/4][31-8*(j%4) -: 8];
    end
  end
  for (int j = 0; j < 16; j++) begin
    ct[127-8*j -: 8] = st[j];
  end
  return ct;
endfunction

`endif

// ==== tb_aes_axi_top.sv ====
`timescale 1ns/1ps
`include "aes_defines.svh"

module tb_aes_axi_top;
  import axi_regs_pkg::*;

  logic        clk_i;
  logic        rst_ni;
  logic [11:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [11:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  logic        irq_o;
  logic        irq_clear_i;

  int seed;
  int err_count;
  int check_count;
  int test_count;
  int test_start_errs;

  `include "tb_aes_model.svh"

  aes_axi_top u_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .awaddr_i    (awaddr),
    .awvalid_i   (awvalid),
    .awready_o   (awready),
    .wdata_i     (wdata),
    .wstrb_i     (wstrb),
    .wvalid_i    (wvalid),
    .wready_o    (wready),
    .bresp_o     (bresp),
    .bvalid_o    (bvalid),
    .bready_i    (bready),
    .araddr_i    (araddr),
    .arvalid_i   (arvalid),
    .arready_o   (arready),
    .rdata_o     (rdata),
    .rresp_o     (rresp),
    .rvalid_o    (rvalid),
    .rready_i    (rready),
    .irq_o       (irq_o),
    .irq_clear_i (irq_clear_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("FAILED at %0d ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display(">>> FAIL");
    $finish;
  endtask

  function automatic logic [11:0] word_addr(input logic [11:0] base, input int idx);
    return 12'(base + 4 * idx);
  endfunction

  function automatic logic [127:0] rand_block();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  task automatic begin_test();
    test_start_errs = err_count;
  endtask

  task automatic end_test(input string name);
    test_count++;
    $display("test %0d %s: %0d errors", test_count, name, err_count - test_start_errs);
  endtask

  // ----------------------------------------------------------
  // AXI driver tasks
  // ----------------------------------------------------------
  // While hold is nonzero the response is held back and a probe request must stay unanswered
  task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input int hold,
                           output logic [1:0] resp);
    int cnt;
    @(posedge clk_i);
    #1;
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = strb;
    wvalid  = 1'b1;
    cnt = 0;
    @(negedge clk_i);
    while (!(awready && wready)) begin
      cnt++;
      if (cnt > 20) begin
        abort_on_timeout("awready and wready");
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    cnt = 0;
    @(negedge clk_i);
    while (!bvalid) begin
      cnt++;
      if (cnt > 20) begin
        abort_on_timeout("bvalid");
      end
      @(negedge clk_i);
    end
    resp = bresp;
    for (int i = 0; i < hold; i++) begin
      @(posedge clk_i);
      #1;
      awaddr  = 12'h100;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      @(negedge clk_i);
      check("bvalid", 128'(bvalid), 128'(1'b1));
      check("bresp", 128'(bresp), 128'(resp));
      check("awready", 128'(awready), 128'(1'b0));
      check("wready", 128'(wready), 128'(1'b0));
    end
    @(posedge clk_i);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    @(posedge clk_i);
    #1;
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [11:0] addr, input int hold,
                          output logic [31:0] data, output logic [1:0] resp);
    int cnt;
    @(posedge clk_i);
    #1;
    araddr  = addr;
    arvalid = 1'b1;
    cnt = 0;
    @(negedge clk_i);
    while (!arready) begin
      cnt++;
      if (cnt > 20) begin
        abort_on_timeout("arready");
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    arvalid = 1'b0;
    cnt = 0;
    @(negedge clk_i);
    while (!rvalid) begin
      cnt++;
      if (cnt > 20) begin
        abort_on_timeout("rvalid");
      end
      @(negedge clk_i);
    end
    data = rdata;
    resp = rresp;
    for (int i = 0; i < hold; i++) begin
      @(posedge clk_i);
      #1;
      araddr  = 12'h100;
      arvalid = 1'b1;
      @(negedge clk_i);
      check("rvalid", 128'(rvalid), 128'(1'b1));
      check("rdata", 128'(rdata), 128'(data));
      check("rresp", 128'(rresp), 128'(resp));
      check("arready", 128'(arready), 128'(1'b0));
    end
    @(posedge clk_i);
    #1;
    arvalid = 1'b0;
    rready  = 1'b1;
    @(posedge clk_i);
    #1;
    rready = 1'b0;
  endtask

  task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
    logic [1:0] resp;
    axi_write(addr, data, 4'hf, 0, resp);
    check("bresp", 128'(resp), 128'(RESP_OKAY));
  endtask

  task automatic read_reg(input logic [11:0] addr, output logic [31:0] data);
    logic [1:0] resp;
    axi_read(addr, 0, data, resp);
    check("rresp", 128'(resp), 128'(RESP_OKAY));
  endtask

  // ----------------------------------------------------------
  // Cipher runs
  // ----------------------------------------------------------
  task automatic load_block(input logic [127:0] key, input logic [127:0] pt);
    for (int i = 0; i < 4; i++) begin
      write_reg(word_addr(`AES_KEY0, i), key[127-32*i -: 32]);
      write_reg(word_addr(`AES_DIN0, i), pt[127-32*i -: 32]);
    end
  endtask

  task automatic wait_idle();
    logic [31:0] status;
    int polls;
    polls = 0;
    read_reg(`AES_STATUS, status);
    while (status[0]) begin
      polls++;
      if (polls > 40) begin
        abort_on_timeout("busy to fall");
      end
      read_reg(`AES_STATUS, status);
    end
  endtask

  task automatic read_result(output logic [127:0] ct);
    logic [31:0] w;
    for (int i = 0; i < 4; i++) begin
      read_reg(word_addr(`AES_DOUT0, i), w);
      ct[127-32*i -: 32] = w;
    end
  endtask

  task automatic run_block(input logic [127:0] key, input logic [127:0] pt,
                           output logic [127:0] ct);
    load_block(key, pt);
    write_reg(`AES_CTRL, 32'h1);
    wait_idle();
    read_result(ct);
  endtask

  task automatic check_irq(input logic exp_irq, input logic [31:0] exp_status);
    logic [31:0] status;
    @(negedge clk_i);
    check("irq_o", 128'(irq_o), 128'(exp_irq));
    read_reg(`AES_STATUS, status);
    check("status", 128'(status), 128'(exp_status));
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    logic [127:0] key;
    logic [127:0] pt;
    logic [127:0] ct;
    logic [127:0] last_ct;
    logic [31:0]  old_w;
    logic [31:0]  new_w;
    logic [31:0]  exp_w;
    logic [31:0]  rd;
    logic [11:0]  addr;
    logic [3:0]   strb;
    logic [1:0]   resp;
    int           hold;

    seed        = 32'h23df_5d17;
    err_count   = 0;
    check_count = 0;
    test_count  = 0;
    rst_ni      = 1'b0;
    awaddr      = '0;
    awvalid     = 1'b0;
    wdata       = '0;
    wstrb       = '0;
    wvalid      = 1'b0;
    bready      = 1'b0;
    araddr      = '0;
    arvalid     = 1'b0;
    rready      = 1'b0;
    irq_clear_i = 1'b0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    begin_test();
    key = 128'h000102030405060708090a0b0c0d0e0f;
    pt  = 128'h00112233445566778899aabbccddeeff;
    check("model ciphertext", ref_encrypt(key, pt), 128'h69c4e0d86a7b0430d8cdb78070b4c55a);
    run_block(key, pt, ct);
    check("dout", ct, 128'h69c4e0d86a7b0430d8cdb78070b4c55a);
    end_test("fips-197 vector");

    // Key and input words are overwritten while each run is in flight
    begin_test();
    last_ct = '0;
    for (int n = 0; n < 20; n++) begin
      key = rand_block();
      pt  = rand_block();
      load_block(key, pt);
      write_reg(`AES_CTRL, 32'h1);
      write_reg(word_addr(`AES_KEY0, 2), $random(seed));
      write_reg(word_addr(`AES_DIN0, 1), $random(seed));
      wait_idle();
      read_result(ct);
      check("dout", ct, ref_encrypt(key, pt));
      last_ct = ct;
    end
    end_test("random blocks");

    begin_test();
    for (int n = 0; n < 16; n++) begin
      addr  = word_addr((n % 8) < 4 ? `AES_KEY0 : `AES_DIN0, n % 4);
      old_w = $random(seed);
      new_w = $random(seed);
      strb  = 4'($random(seed));
      write_reg(addr, old_w);
      axi_write(addr, new_w, strb, 0, resp);
      check("bresp", 128'(resp), 128'(RESP_OKAY));
      for (int b = 0; b < 4; b++) begin
        exp_w[8*b +: 8] = strb[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
      end
      read_reg(addr, rd);
      check("rdata", 128'(rd), 128'(exp_w));
    end
    end_test("byte strobes");

    begin_test();
    for (int i = 0; i < 4; i++) begin
      axi_write(word_addr(`AES_DOUT0, i), $random(seed), 4'hf, 0, resp);
      check("bresp", 128'(resp), 128'(RESP_SLVERR));
    end
    axi_write(12'h008, $random(seed), 4'hf, 0, resp);
    check("bresp", 128'(resp), 128'(RESP_SLVERR));
    axi_write(12'h040, $random(seed), 4'hf, 0, resp);
    check("bresp", 128'(resp), 128'(RESP_SLVERR));
    read_result(ct);
    check("dout", ct, last_ct);
    axi_read(12'h00c, 0, rd, resp);
    check("rdata", 128'(rd), 128'(0));
    check("rresp", 128'(resp), 128'(RESP_SLVERR));
    axi_read(12'hffc, 0, rd, resp);
    check("rdata", 128'(rd), 128'(0));
    check("rresp", 128'(resp), 128'(RESP_SLVERR));
    end_test("error responses");

    begin_test();
    write_reg(`AES_STATUS, 32'h2);
    check_irq(1'b0, 32'h0);
    key = rand_block();
    pt  = rand_block();
    run_block(key, pt, ct);
    check("dout", ct, ref_encrypt(key, pt));
    check_irq(1'b1, 32'h2);
    @(posedge clk_i);
    #1;
    irq_clear_i = 1'b1;
    @(posedge clk_i);
    #1;
    irq_clear_i = 1'b0;
    check_irq(1'b0, 32'h0);
    run_block(rand_block(), rand_block(), ct);
    check_irq(1'b1, 32'h2);
    axi_write(`AES_STATUS, 32'h2, 4'h1, 0, resp);
    check("bresp", 128'(resp), 128'(RESP_OKAY));
    check_irq(1'b0, 32'h0);
    end_test("interrupt");

    begin_test();
    for (int n = 0; n < 6; n++) begin
      addr  = word_addr(`AES_KEY0, n % 4);
      new_w = $random(seed);
      hold  = 1 + ($random(seed) & 7);
      axi_write(addr, new_w, 4'hf, hold, resp);
      check("bresp", 128'(resp), 128'(RESP_OKAY));
      hold = 1 + ($random(seed) & 7);
      axi_read(addr, hold, rd, resp);
      check("rresp", 128'(resp), 128'(RESP_OKAY));
      check("rdata", 128'(rd), 128'(new_w));
    end
    end_test("response backpressure");

    $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+.
aes_types_pkg.sv
axi_regs_pkg.sv
aes_ifs.sv
aes_sbox.sv
aes_round_core.sv
aes_reg_file.sv
axi_lite_slave.sv
aes_axi_top.sv
tb_aes_axi_top.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module tb_aes_axi_top

sim:
	verilator --binary --timing -j 0 -f verilog.f --top-module tb_aes_axi_top -Mdir obj_dir
	./obj_dir/Vtb_aes_axi_top | tee $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
